/* source/ads_cfg.svh */
`ifndef ADS_CFG_SVH
`define ADS_CFG_SVH

// system clocks per sclk half period
// one byte on the wire is 16 of these
`define ADS_SPI_HALF_BIT 4

// csn stays low this long after the last sclk fall
// device wants 4 tclk or more before csn goes high
`define ADS_CS_HOLD_CLKS 6

// pwdn/reset low pulse length in clocks
`define ADS_RESET_PULSE_CLKS 8

// register address field inside the first opcode byte
`define ADS_REG_ADDR_W 5

`endif

/* source/ads_pkg.sv */
package ads_pkg;

	typedef logic [7:0] ads_byte_t; // one spi byte

	// host control code, 3'b100 and up decode as idle
	typedef enum logic [2:0] {
		CB_IDLE   = 3'b000,
		CB_SYSCMD = 3'b001, // uses i_command
		CB_WREG   = 3'b010, // uses i_reg_addr and i_wdata
		CB_RREG   = 3'b011  // uses i_reg_addr
	} ads_ctl_e;

	// these three go to pins, everything else is sent as an spi byte
	typedef enum logic [7:0] {
		CM_RESET = 8'h06,
		CM_START = 8'h08,
		CM_STOP  = 8'h0A
	} ads_cmd_e;

	localparam logic [2:0] OP_RREG    = 3'b001; // 001r_rrrr
	localparam logic [2:0] OP_WREG    = 3'b010; // 010r_rrrr
	localparam ads_byte_t  OP_NUM_ONE = 8'h00;  // register count minus one

	typedef enum logic [3:0] {
		ST_IDLE      = 4'd0,
		ST_PIN       = 4'd1, // start/stop/reset pulse issued
		ST_RST_WAIT  = 4'd2, // reset pin still low
		ST_SEND      = 4'd3, // hand next byte to spi engine
		ST_WAIT_BYTE = 4'd4,
		ST_HOLD      = 4'd5  // csn hold after last byte
	} ads_seq_state_e;

endpackage

/* source/spi_byte_master.sv */
module spi_byte_master #(
	parameter int CLKS_PER_HALF_BIT = 4 // even, 2 or more
) (
	input  logic               clk,
	input  logic               rstn,
	input  ads_pkg::ads_byte_t i_tx_byte,
	input  logic               i_tx_dv,
	output logic               o_tx_ready,
	output logic               o_rx_dv,
	output ads_pkg::ads_byte_t o_rx_byte,
	output logic               o_sclk,
	output logic               o_mosi,
	input  logic               i_miso
);
	import ads_pkg::*;

	localparam int HB_W = $clog2(CLKS_PER_HALF_BIT);
	localparam logic [HB_W-1:0] HB_LAST = HB_W'(CLKS_PER_HALF_BIT - 1);

	logic [HB_W-1:0] hb_cnt;    // clocks spent in current half bit
	logic [4:0]      edge_cnt;  // sclk edges still to go, 16 per byte
	logic            half_done; // sclk toggles this cycle
	logic            last_edge;
	ads_byte_t       tx_shift;  // msb sits on mosi
	ads_byte_t       rx_shift;

	assign half_done = (edge_cnt != 5'd0) && (hb_cnt == HB_LAST);
	assign last_edge = half_done && (edge_cnt == 5'd1); // final falling edge
	assign o_mosi = tx_shift[7];

	// mode 0 so sclk idles low
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			hb_cnt     <= '0;
			edge_cnt   <= 5'd0;
			o_sclk     <= 1'b0;
			o_tx_ready <= 1'b1;
			o_rx_dv    <= 1'b0;
			tx_shift   <= '0; // keeps mosi low out of reset
		end else begin
			o_rx_dv <= 1'b0;
			if (i_tx_dv && o_tx_ready) begin
				tx_shift   <= i_tx_byte; // bit 7 valid before first rise
				edge_cnt   <= 5'd16;
				hb_cnt     <= '0;
				o_tx_ready <= 1'b0;
			end else if (half_done) begin
				hb_cnt   <= '0;
				o_sclk   <= ~o_sclk;
				edge_cnt <= edge_cnt - 5'd1;
				// falling edge moves the next bit onto mosi
				if (o_sclk) begin
					tx_shift <= {tx_shift[6:0], 1'b0};
				end
				if (last_edge) begin
					o_tx_ready <= 1'b1; // byte done
					o_rx_dv    <= 1'b1;
				end
			end else if (edge_cnt != 5'd0) begin
				hb_cnt <= hb_cnt + 1'b1;
			end
		end
	end

	// miso taken on the rising edge, msb first
	always_ff @(posedge clk) begin
		if (half_done && !o_sclk) begin
			rx_shift <= {rx_shift[6:0], i_miso};
		end
		if (last_edge) begin
			o_rx_byte <= rx_shift; // all 8 bits in after the 8th rise
		end
	end

endmodule

/* source/ads_pin_regs.sv */
`include "ads_cfg.svh"

module ads_pin_regs (
	input  logic clk,
	input  logic rstn,
	input  logic i_start_set,
	input  logic i_start_clr,
	input  logic i_reset_go,
	output logic o_ads_start,
	output logic o_ads_reset_n,
	output logic o_reset_active
);
	localparam int RST_W = $clog2(`ADS_RESET_PULSE_CLKS + 1);
	localparam logic [RST_W-1:0] RST_LOAD = RST_W'(`ADS_RESET_PULSE_CLKS);

	logic [RST_W-1:0] rst_cnt; // reset pulse cycles left

	// start pin level, conversions run while high
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_ads_start <= 1'b0;
		end else if (i_start_set) begin
			o_ads_start <= 1'b1;
		end else if (i_start_clr) begin
			o_ads_start <= 1'b0;
		end
	end

	// pwdn/reset pin, registered so the pin never glitches
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rst_cnt       <= '0;
			o_ads_reset_n <= 1'b1;
		end else if (i_reset_go) begin
			rst_cnt       <= RST_LOAD;
			o_ads_reset_n <= 1'b0; // pulse starts
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
			if (rst_cnt == RST_W'(1)) begin
				o_ads_reset_n <= 1'b1;
			end
		end
	end

	assign o_reset_active = (rst_cnt != '0); // sequencer waits on this

endmodule

/* source/ads_seq.sv */
`include "ads_cfg.svh"

module ads_seq (
	input  logic               clk,
	input  logic               rstn,
	input  ads_pkg::ads_ctl_e  i_control,
	input  ads_pkg::ads_byte_t i_command,
	input  ads_pkg::ads_byte_t i_reg_addr,
	input  ads_pkg::ads_byte_t i_wdata,
	output ads_pkg::ads_byte_t o_rdata,
	output logic               o_busy,
	output logic               o_spi_csn,
	output ads_pkg::ads_byte_t o_tx_byte,
	output logic               o_tx_dv,
	input  logic               i_tx_ready,
	input  logic               i_rx_dv,
	input  ads_pkg::ads_byte_t i_rx_byte,
	output logic               o_start_set,
	output logic               o_start_clr,
	output logic               o_reset_go,
	input  logic               i_reset_active
);
	import ads_pkg::*;

	localparam int HOLD_W = $clog2(`ADS_CS_HOLD_CLKS + 1);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`ADS_CS_HOLD_CLKS - 1);

	ads_seq_state_e             state;
	ads_ctl_e                   ctl_q;    // request being served
	ads_byte_t                  cmd_q;
	logic [`ADS_REG_ADDR_W-1:0] addr_q;   // only 5 address bits reach the device
	ads_byte_t                  wdata_q;
	ads_byte_t                  rx_hold;  // latest byte back from miso
	logic [1:0]                 byte_idx; // position in frame
	logic [1:0]                 last_idx;
	logic [HOLD_W-1:0]          hold_cnt;
	logic                       accept;
	logic                       pin_cmd;  // start/stop/reset never touch spi
	ads_byte_t                  frame_byte;

	assign accept = (state == ST_IDLE) && (i_control inside {CB_SYSCMD, CB_WREG, CB_RREG});
	assign pin_cmd = (i_control == CB_SYSCMD) &&
		(i_command inside {CM_START, CM_STOP, CM_RESET});
	assign last_idx = (ctl_q == CB_SYSCMD) ? 2'd0 : 2'd2; // 1 or 3 byte frame

	// byte to send for current frame position
	always_comb begin
		frame_byte = OP_NUM_ONE; // second byte of wreg and rreg
		case (byte_idx)
			2'd0: begin
				if (ctl_q == CB_WREG) begin
					frame_byte = {OP_WREG, addr_q};
				end else if (ctl_q == CB_RREG) begin
					frame_byte = {OP_RREG, addr_q};
				end else begin
					frame_byte = cmd_q; // opaque command byte
				end
			end
			2'd2: begin
				// rreg clocks a dummy 00 out while the data comes in
				frame_byte = (ctl_q == CB_WREG) ? wdata_q : 8'h00;
			end
			default: begin
				frame_byte = OP_NUM_ONE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state       <= ST_IDLE;
			ctl_q       <= CB_IDLE;
			o_busy      <= 1'b0;
			o_spi_csn   <= 1'b1;
			o_tx_dv     <= 1'b0;
			o_start_set <= 1'b0;
			o_start_clr <= 1'b0;
			o_reset_go  <= 1'b0;
			byte_idx    <= 2'd0;
			hold_cnt    <= '0;
			o_rdata     <= '0;
		end else begin
			o_tx_dv     <= 1'b0; // all pulses last one cycle
			o_start_set <= 1'b0;
			o_start_clr <= 1'b0;
			o_reset_go  <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						ctl_q    <= i_control;
						o_busy   <= 1'b1;
						byte_idx <= 2'd0;
						if (pin_cmd) begin
							o_start_set <= (i_command == CM_START);
							o_start_clr <= (i_command == CM_STOP);
							o_reset_go  <= (i_command == CM_RESET);
							state       <= ST_PIN; // csn stays high
						end else begin
							o_spi_csn <= 1'b0; // frame opens with busy
							state     <= ST_SEND;
						end
					end
				end
				ST_PIN: begin
					// pin regs load the reset counter this edge
					if (cmd_q == CM_RESET) begin
						state <= ST_RST_WAIT;
					end else begin
						o_busy <= 1'b0; // start/stop done in one cycle
						state  <= ST_IDLE;
					end
				end
				ST_RST_WAIT: begin
					if (!i_reset_active) begin
						o_busy <= 1'b0;
						state  <= ST_IDLE;
					end
				end
				ST_SEND: begin
					if (i_tx_ready) begin
						o_tx_dv <= 1'b1;
						state   <= ST_WAIT_BYTE;
					end
				end
				ST_WAIT_BYTE: begin
					// rx_dv comes with tx_ready rising
					if (i_rx_dv) begin
						if (byte_idx == last_idx) begin
							hold_cnt <= HOLD_W'(1); // ready rise counts as the first
							state    <= ST_HOLD;
						end else begin
							byte_idx <= byte_idx + 2'd1;
							state    <= ST_SEND;
						end
					end
				end
				ST_HOLD: begin
					if (hold_cnt == HOLD_LAST) begin
						o_spi_csn <= 1'b1;
						o_busy    <= 1'b0;
						state     <= ST_IDLE;
						if (ctl_q == CB_RREG) begin
							o_rdata <= rx_hold; // third byte of the frame
						end
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// operands and bytes in flight
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q   <= i_command;
			addr_q  <= i_reg_addr[`ADS_REG_ADDR_W-1:0];
			wdata_q <= i_wdata;
		end
		if (state == ST_SEND && i_tx_ready) begin
			o_tx_byte <= frame_byte;
		end
		if (state == ST_WAIT_BYTE && i_rx_dv) begin
			rx_hold <= i_rx_byte;
		end
	end

endmodule

/* source/ads_ctrl_top.sv */
`include "ads_cfg.svh"

module ads_ctrl_top (
	input  logic               clk,
	input  logic               rstn,
	input  ads_pkg::ads_ctl_e  i_control,
	input  ads_pkg::ads_byte_t i_command,
	input  ads_pkg::ads_byte_t i_reg_addr,
	input  ads_pkg::ads_byte_t i_wdata,
	output ads_pkg::ads_byte_t o_rdata,
	output logic               o_busy,
	output logic               o_spi_clk,
	output logic               o_spi_mosi,
	input  logic               i_spi_miso,
	output logic               o_spi_csn,
	output logic               o_ads_start,
	output logic               o_ads_reset_n
);
	import ads_pkg::*;

	// sequencer to spi engine
	ads_byte_t tx_byte;
	logic      tx_dv;
	logic      tx_ready;
	logic      rx_dv;
	ads_byte_t rx_byte;

	// sequencer to pin regs
	logic start_set;
	logic start_clr;
	logic reset_go;
	logic reset_active;

	ads_seq u_seq (
		.clk            (clk),
		.rstn           (rstn),
		.i_control      (i_control),
		.i_command      (i_command),
		.i_reg_addr     (i_reg_addr),
		.i_wdata        (i_wdata),
		.o_rdata        (o_rdata),
		.o_busy         (o_busy),
		.o_spi_csn      (o_spi_csn),
		.o_tx_byte      (tx_byte),
		.o_tx_dv        (tx_dv),
		.i_tx_ready     (tx_ready),
		.i_rx_dv        (rx_dv),
		.i_rx_byte      (rx_byte),
		.o_start_set    (start_set),
		.o_start_clr    (start_clr),
		.o_reset_go     (reset_go),
		.i_reset_active (reset_active)
	);

	ads_pin_regs u_pins (
		.clk            (clk),
		.rstn           (rstn),
		.i_start_set    (start_set),
		.i_start_clr    (start_clr),
		.i_reset_go     (reset_go),
		.o_ads_start    (o_ads_start),
		.o_ads_reset_n  (o_ads_reset_n),
		.o_reset_active (reset_active)
	);

	// mode 0 byte engine
	spi_byte_master #(
		.CLKS_PER_HALF_BIT (`ADS_SPI_HALF_BIT)
	) u_spi (
		.clk        (clk),
		.rstn       (rstn),
		.i_tx_byte  (tx_byte),
		.i_tx_dv    (tx_dv),
		.o_tx_ready (tx_ready),
		.o_rx_dv    (rx_dv),
		.o_rx_byte  (rx_byte),
		.o_sclk     (o_spi_clk),
		.o_mosi     (o_spi_mosi),
		.i_miso     (i_spi_miso)
	);

endmodule

/* test/ads_spi_slave.sv */
`include "ads_cfg.svh"

module ads_spi_slave (
	input  logic i_sclk,
	input  logic i_mosi,
	input  logic i_csn,
	output logic o_miso
);
	timeunit 1ns;
	timeprecision 1ps;
	import ads_pkg::*;

	ads_byte_t                  regs [0:31];     // device register file
	ads_byte_t                  cur_q [$];       // bytes of the open window
	ads_byte_t                  win_bytes [$];   // bytes of the last closed window
	int                         window_cnt = 0;
	logic                       open = 1'b0;
	int                         bit_cnt = 0;     // rising edges in current byte
	ads_byte_t                  shift_in = '0;
	ads_byte_t                  out_byte = '0;   // goes out msb first
	logic                       miso_q = 1'b0;
	logic [2:0]                 opcode = '0;
	logic [`ADS_REG_ADDR_W-1:0] addr = '0;       // only 5 bits reach the file

	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = 8'h00; // power-on value
		end
	end

	// one process for csn edges and sclk rise
	always @(posedge i_sclk or posedge i_csn or negedge i_csn) begin
		if (i_csn === 1'b1) begin
			if (open) begin
				win_bytes = cur_q; // window closed
				window_cnt++;
			end
			open = 1'b0;
		end else if (!open) begin
			open = 1'b1; // csn just fell
			cur_q.delete();
			bit_cnt = 0;
			out_byte = '0;
		end else begin
			shift_in = {shift_in[6:0], i_mosi}; // mode 0, sample on rise
			bit_cnt++;
			if (bit_cnt == 8) begin
				bit_cnt = 0;
				out_byte = '0;
				cur_q.push_back(shift_in);
				case (cur_q.size())
					1: begin
						opcode = shift_in[7:5];
						addr   = shift_in[`ADS_REG_ADDR_W-1:0];
					end
					2: begin
						if (opcode == OP_RREG) begin
							out_byte = regs[addr]; // shifted out during byte 3
						end
					end
					3: begin
						if (opcode == OP_WREG) begin
							regs[addr] = shift_in;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// next bit on the falling edge, ready before the next rise
	always @(negedge i_sclk) begin
		miso_q <= out_byte[7 - bit_cnt];
	end

	assign o_miso = i_csn ? 1'b0 : miso_q;

endmodule

/* test/ads_ctrl_props.sv */
`include "ads_cfg.svh"

module ads_ctrl_props (
	input logic                    clk,
	input logic                    rstn,
	input logic                    i_busy,
	input logic                    i_spi_csn,
	input logic                    i_spi_clk,
	input logic                    i_ads_reset_n,
	input ads_pkg::ads_seq_state_e i_state
);
	timeunit 1ns;
	timeprecision 1ps;
	import ads_pkg::*;

	// mode 0 clock idles low outside a frame
	sclk_idle_a: assert property (@(posedge clk) disable iff (!rstn)
		i_spi_csn |-> !i_spi_clk)
		else $error("sclk high while chip select is high");

	csn_busy_a: assert property (@(posedge clk) disable iff (!rstn)
		!i_busy |-> i_spi_csn)
		else $error("chip select low while the controller is not busy");

	// no spi traffic during the device reset pulse
	csn_reset_a: assert property (@(posedge clk) disable iff (!rstn)
		!i_ads_reset_n |-> i_spi_csn)
		else $error("chip select low while the reset pin is low");

	cs_hold_a: assert property (@(posedge clk) disable iff (!rstn)
		$fell(i_spi_clk) |-> !i_spi_csn [*`ADS_CS_HOLD_CLKS])
		else $error("chip select released too soon after the last sclk fall");

	// engine has finished the byte before the hold starts
	hold_sclk_a: assert property (@(posedge clk) disable iff (!rstn)
		(i_state == ST_HOLD) |-> !i_spi_clk)
		else $error("sclk high while the sequencer holds chip select");

endmodule

bind ads_ctrl_top ads_ctrl_props u_props (
	.clk           (clk),
	.rstn          (rstn),
	.i_busy        (o_busy),
	.i_spi_csn     (o_spi_csn),
	.i_spi_clk     (o_spi_clk),
	.i_ads_reset_n (o_ads_reset_n),
	.i_state       (u_seq.state)
);

/* test/tb_ads_ctrl.sv */
`include "ads_cfg.svh"

module tb_ads_ctrl;
	timeunit 1ns;
	timeprecision 1ps;
	import ads_pkg::*;

	localparam int NUM_OPS    = 300;
	localparam int MAX_CYCLES = NUM_OPS * 260; // 3 byte frame is 192 clocks, plus hold

	logic        clk;
	logic        rstn;
	ads_ctl_e    control;
	ads_byte_t   command;
	ads_byte_t   reg_addr;
	ads_byte_t   wdata;
	ads_byte_t   rdata;
	logic        busy;
	logic        spi_clk;
	logic        spi_mosi;
	logic        spi_miso;
	logic        spi_csn;
	logic        ads_start;
	logic        ads_reset_n;
	logic [31:0] rng = 32'h3377_fb8b;
	ads_byte_t   model_regs [0:31]; // expected device registers
	logic        start_exp;         // expected START pin
	ads_byte_t   rdata_exp;
	int          cycles = 0;

	ads_ctrl_top dut (
		.clk           (clk),
		.rstn          (rstn),
		.i_control     (control),
		.i_command     (command),
		.i_reg_addr    (reg_addr),
		.i_wdata       (wdata),
		.o_rdata       (rdata),
		.o_busy        (busy),
		.o_spi_clk     (spi_clk),
		.o_spi_mosi    (spi_mosi),
		.i_spi_miso    (spi_miso),
		.o_spi_csn     (spi_csn),
		.o_ads_start   (ads_start),
		.o_ads_reset_n (ads_reset_n)
	);

	ads_spi_slave u_slave (
		.i_sclk (spi_clk),
		.i_mosi (spi_mosi),
		.i_csn  (spi_csn),
		.o_miso (spi_miso)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			stop_on_failure();
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic check_eq(input string name, input int unsigned exp, input int unsigned act);
		assert (exp == act) else begin
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
			stop_on_failure();
		end
	endtask

	// one request, then follow busy until it drops; called 1 ns after an edge
	task automatic run_request(input ads_ctl_e ctl, input ads_byte_t cmd,
			input ads_byte_t addr, input ads_byte_t data, input logic spi_op,
			output int busy_cyc, output int hold_cyc, output int rst_low,
			output logic rst_n_last);
		control  = ctl;
		command  = cmd;
		reg_addr = addr;
		wdata    = data;
		@(posedge clk);
		#1;
		control = CB_IDLE; // taken on that edge
		check_eq("accept_busy", 1, busy);
		busy_cyc   = 0;
		hold_cyc   = 0;
		rst_low    = 0;
		rst_n_last = 1'b1;
		while (busy) begin
			busy_cyc++;
			check_eq("csn_while_busy", spi_op ? 0 : 1, spi_csn);
			check_eq("rdata_stable", rdata_exp, rdata); // only moves as busy falls
			if (!ads_reset_n) begin
				rst_low++;
			end
			hold_cyc   = spi_clk ? 0 : hold_cyc + 1; // clocks since sclk last high
			rst_n_last = ads_reset_n;
			@(posedge clk);
			#1;
		end
		check_eq("csn_at_busy_fall", 1, spi_csn);
	endtask

	initial begin
		int                         sel;
		int                         busy_cyc;
		int                         hold_cyc;
		int                         rst_low;
		int                         frames0;
		logic                       rst_n_last;
		logic [31:0]                r;
		ads_byte_t                  addr;
		ads_byte_t                  data;
		ads_byte_t                  cmd;
		logic [`ADS_REG_ADDR_W-1:0] a5;
		ads_byte_t                  exp_frame [$];

		rstn     = 1'b0;
		control  = CB_IDLE;
		command  = '0;
		reg_addr = '0;
		wdata    = '0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = 8'h00;
		end
		start_exp = 1'b0;
		rdata_exp = 8'h00;
		repeat (4) @(posedge clk);
		#1;
		rstn = 1'b1;
		check_eq("reset_csn", 1, spi_csn);
		check_eq("reset_reset_n", 1, ads_reset_n);
		check_eq("reset_busy", 0, busy);
		check_eq("reset_start", 0, ads_start);
		check_eq("reset_sclk", 0, spi_clk);

		for (int n = 0; n < NUM_OPS; n++) begin
			sel     = next_rand() % 8;
			addr    = 8'(next_rand()); // upper 3 bits must be dropped
			data    = 8'(next_rand());
			cmd     = 8'(next_rand()); // ignored unless syscmd
			r       = next_rand();
			a5      = addr[`ADS_REG_ADDR_W-1:0];
			frames0 = u_slave.window_cnt;
			exp_frame.delete();
			case (sel)
				0, 1, 2: begin
					exp_frame.push_back({3'b010, a5});
					exp_frame.push_back(8'h00);
					exp_frame.push_back(data);
					run_request(CB_WREG, cmd, addr, data, 1'b1, busy_cyc, hold_cyc,
						rst_low, rst_n_last);
					model_regs[a5] = data;
				end
				3, 4: begin
					exp_frame.push_back({3'b001, a5});
					exp_frame.push_back(8'h00);
					exp_frame.push_back(8'h00); // dummy while data comes back
					run_request(CB_RREG, cmd, addr, data, 1'b1, busy_cyc, hold_cyc,
						rst_low, rst_n_last);
					rdata_exp = model_regs[a5];
					check_eq("rreg_rdata", rdata_exp, rdata);
				end
				5: begin
					case (r % 3)
						0: cmd = 8'h02;
						1: cmd = 8'h04;
						default: cmd = 8'h1A;
					endcase
					exp_frame.push_back(cmd);
					run_request(CB_SYSCMD, cmd, addr, data, 1'b1, busy_cyc, hold_cyc,
						rst_low, rst_n_last);
				end
				6: begin
					cmd = r[0] ? 8'h08 : 8'h0A; // start or stop
					run_request(CB_SYSCMD, cmd, addr, data, 1'b0, busy_cyc, hold_cyc,
						rst_low, rst_n_last);
					start_exp = (cmd == 8'h08);
					check_eq("pin_busy_cycles", 1, busy_cyc);
				end
				default: begin
					run_request(CB_SYSCMD, 8'h06, addr, data, 1'b0, busy_cyc, hold_cyc,
						rst_low, rst_n_last);
					check_eq("reset_low_cycles", `ADS_RESET_PULSE_CLKS, rst_low);
					check_eq("reset_end_before_busy_fall", 1, rst_n_last);
				end
			endcase
			if (sel != 7) begin
				check_eq("no_reset_pulse", 0, rst_low);
			end
			check_eq("start_level", start_exp, ads_start);
			check_eq("reset_pin_idle", 1, ads_reset_n);
			check_eq("rdata_kept", rdata_exp, rdata);
			check_eq("cs_windows", frames0 + (exp_frame.size() != 0), u_slave.window_cnt);
			if (exp_frame.size() != 0) begin
				assert (hold_cyc >= `ADS_CS_HOLD_CLKS) else begin
					$display("ERROR cs_hold: expected at least %0d, actual %0d",
						`ADS_CS_HOLD_CLKS, hold_cyc);
					stop_on_failure();
				end
				check_eq("frame_len", exp_frame.size(), u_slave.win_bytes.size());
				foreach (exp_frame[i]) begin
					check_eq($sformatf("frame_byte%0d", i), exp_frame[i], u_slave.win_bytes[i]);
				end
			end
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+source
source/ads_pkg.sv
source/spi_byte_master.sv
source/ads_pin_regs.sv
source/ads_seq.sv
source/ads_ctrl_top.sv
test/ads_spi_slave.sv
test/ads_ctrl_props.sv
test/tb_ads_ctrl.sv

/* Bender.yml */
package:
  name: ads_ctrl

sources:
  - include_dirs:
      - source
    files:
      - source/ads_pkg.sv
      - source/spi_byte_master.sv
      - source/ads_pin_regs.sv
      - source/ads_seq.sv
      - source/ads_ctrl_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/ads_spi_slave.sv
      - test/ads_ctrl_props.sv
      - test/tb_ads_ctrl.sv
